// ==== hw/bpred_pkg.sv ====
package bpred_pkg;

    // addresses and targets
    typedef logic [31:0] word_t;

    // control-flow kind kept in the BTB
    typedef enum logic [1:0] {
        cf_br   = 2'b00,
        cf_jal  = 2'b01,
        cf_jalr = 2'b10
    } cf_kind_t;

    // 2-bit saturating counter whose msb is the prediction
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_reset = 2'b01; // weakly not taken / weakly local
    localparam ctr_t ctr_max   = 2'b11; // strongly taken / strongly global
    localparam ctr_t ctr_min   = 2'b00; // strongly not taken / strongly local

    // bank positions in the generate loop
    localparam int pht_global  = 0;
    localparam int pht_local   = 1;
    localparam int pht_chooser = 2;
    localparam int num_pht     = 3;

endpackage : bpred_pkg

// ==== hw/predictor_index.sv ====
`timescale 1ns/10ps

module predictor_index #(
    parameter int history_depth = 8,
    parameter int bht_s_index   = 6
) (
    input  logic                   clk,
    input  logic                   arst_n,

    input  bpred_pkg::word_t       lookup_pc,

    input  logic                   resolve_valid,
    input  bpred_pkg::word_t       resolve_pc,
    input  bpred_pkg::cf_kind_t    resolve_kind,
    input  logic                   resolve_taken,

    output logic [bpred_pkg::num_pht-1:0][history_depth-1:0] read_index,
    output logic [bpred_pkg::num_pht-1:0][history_depth-1:0] write_index
);

    localparam int bht_entries = 2 ** bht_s_index;

    logic [history_depth-1:0] ghr;
    logic [history_depth-1:0] bht [bht_entries];
    logic [bht_s_index-1:0]   bht_rd_idx;
    logic [bht_s_index-1:0]   bht_wr_idx;
    logic [history_depth-1:0] bht_wr_hist;
    logic                     br_resolve;

    assign bht_rd_idx  = lookup_pc[bht_s_index+1:2];  // word aligned pc
    assign bht_wr_idx  = resolve_pc[bht_s_index+1:2];
    assign bht_wr_hist = bht[bht_wr_idx];
    assign br_resolve  = resolve_valid && (resolve_kind == bpred_pkg::cf_br);

    // lookup side sees the histories as they stand before this edge
    always_comb begin
        read_index[bpred_pkg::pht_global]  = ghr;
        read_index[bpred_pkg::pht_local]   = bht[bht_rd_idx];
        read_index[bpred_pkg::pht_chooser] = lookup_pc[history_depth+1:2];
    end

    // update side uses pre-shift history of the resolved pc
    always_comb begin
        write_index[bpred_pkg::pht_global]  = ghr;
        write_index[bpred_pkg::pht_local]   = bht_wr_hist;
        write_index[bpred_pkg::pht_chooser] = resolve_pc[history_depth+1:2];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ghr <= '0;
        end else if (br_resolve) begin
            ghr <= {ghr[history_depth-2:0], resolve_taken}; // newest outcome at lsb
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < bht_entries; i++) begin
                bht[i] <= '0;
            end
        end else if (br_resolve) begin
            bht[bht_wr_idx] <= {bht_wr_hist[history_depth-2:0], resolve_taken};
        end
    end

endmodule : predictor_index

// ==== hw/pht_bank.sv ====
`timescale 1ns/10ps

module pht_bank #(
    parameter int history_depth = 8
) (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic [history_depth-1:0] read_index,
    input  logic [history_depth-1:0] write_index,
    input  logic                     increment,
    input  logic                     decrement,

    output bpred_pkg::ctr_t          read_ctr,
    output bpred_pkg::ctr_t          write_ctr
);

    localparam int num_entries = 2 ** history_depth;

    bpred_pkg::ctr_t table_q [num_entries];

    assign read_ctr  = table_q[read_index];
    assign write_ctr = table_q[write_index]; // current value before training

    // saturating step at the write index
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_entries; i++) begin
                table_q[i] <= bpred_pkg::ctr_reset;
            end
        end else if (increment) begin
            if (write_ctr != bpred_pkg::ctr_max) begin
                table_q[write_index] <= write_ctr + 2'd1;
            end
        end else if (decrement) begin
            if (write_ctr != bpred_pkg::ctr_min) begin
                table_q[write_index] <= write_ctr - 2'd1;
            end
        end
    end

endmodule : pht_bank

// ==== hw/tournament_select.sv ====
`timescale 1ns/10ps

module tournament_select (
    input  bpred_pkg::ctr_t [bpred_pkg::num_pht-1:0] read_ctr,
    input  bpred_pkg::ctr_t [bpred_pkg::num_pht-1:0] write_ctr,

    input  logic                                     resolve_valid,
    input  bpred_pkg::cf_kind_t                      resolve_kind,
    input  logic                                     resolve_taken,

    output logic                                     branch_taken,
    output logic [bpred_pkg::num_pht-1:0]            bank_increment,
    output logic [bpred_pkg::num_pht-1:0]            bank_decrement
);

    logic global_pr;
    logic local_pr;
    logic use_global;
    logic br_resolve;
    logic global_wr_pr;
    logic local_wr_pr;
    logic disagree;

    assign global_pr  = read_ctr[bpred_pkg::pht_global][1];
    assign local_pr   = read_ctr[bpred_pkg::pht_local][1];
    assign use_global = read_ctr[bpred_pkg::pht_chooser][1]; // 1 picks global

    assign branch_taken = use_global ? global_pr : local_pr;

    assign br_resolve   = resolve_valid && (resolve_kind == bpred_pkg::cf_br);
    assign global_wr_pr = write_ctr[bpred_pkg::pht_global][1];
    assign local_wr_pr  = write_ctr[bpred_pkg::pht_local][1];
    assign disagree     = global_wr_pr != local_wr_pr;

    always_comb begin
        bank_increment = '0;
        bank_decrement = '0;
        if (br_resolve) begin
            // direction tables follow the outcome
            bank_increment[bpred_pkg::pht_global] = resolve_taken;
            bank_decrement[bpred_pkg::pht_global] = !resolve_taken;
            bank_increment[bpred_pkg::pht_local]  = resolve_taken;
            bank_decrement[bpred_pkg::pht_local]  = !resolve_taken;

            // chooser only trains when the two predictors disagree
            if (disagree) begin
                if (global_wr_pr == resolve_taken) begin
                    bank_increment[bpred_pkg::pht_chooser] = 1'b1; // toward global
                end else begin
                    bank_decrement[bpred_pkg::pht_chooser] = 1'b1; // toward local
                end
            end
        end
    end

endmodule : tournament_select

// ==== hw/btb.sv ====
`timescale 1ns/10ps

module btb #(
    parameter int btb_s_index = 5
) (
    input  logic                clk,
    input  logic                arst_n,

    input  bpred_pkg::word_t    lookup_pc,

    input  logic                resolve_valid,
    input  bpred_pkg::word_t    resolve_pc,
    input  bpred_pkg::cf_kind_t resolve_kind,
    input  bpred_pkg::word_t    resolve_target,

    output logic                hit,
    output bpred_pkg::word_t    target,
    output bpred_pkg::cf_kind_t kind
);

    localparam int num_entries = 2 ** btb_s_index;
    localparam int tag_width   = 30 - btb_s_index; // pc[31:btb_s_index+2]

    logic [num_entries-1:0] valid;
    logic [tag_width-1:0]   tag_q    [num_entries];
    bpred_pkg::word_t       target_q [num_entries];
    bpred_pkg::cf_kind_t    kind_q   [num_entries];

    logic [btb_s_index-1:0] rd_idx;
    logic [btb_s_index-1:0] wr_idx;
    logic [tag_width-1:0]   rd_tag;
    logic [tag_width-1:0]   wr_tag;
    bpred_pkg::word_t       wr_target;

    assign rd_idx = lookup_pc[btb_s_index+1:2];
    assign rd_tag = lookup_pc[31:btb_s_index+2];
    assign wr_idx = resolve_pc[btb_s_index+1:2];
    assign wr_tag = resolve_pc[31:btb_s_index+2];

    // jalr target is stored with bit 0 cleared
    assign wr_target = (resolve_kind == bpred_pkg::cf_jalr) ?
                       {resolve_target[31:1], 1'b0} : resolve_target;

    assign hit    = valid[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target = hit ? target_q[rd_idx] : '0;           // zero on a miss
    assign kind   = hit ? kind_q[rd_idx] : bpred_pkg::cf_br;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else if (resolve_valid) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (resolve_valid) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target;
            kind_q[wr_idx]   <= resolve_kind;
        end
    end

endmodule : btb

// ==== hw/bpred_perf.sv ====
`timescale 1ns/10ps

module bpred_perf #(
    parameter int perf_counter_width = 16
) (
    input  logic                          clk,
    input  logic                          arst_n,

    input  logic                          resolve_valid,
    input  bpred_pkg::cf_kind_t           resolve_kind,
    input  logic                          resolve_taken,
    input  bpred_pkg::word_t              resolve_target,
    input  logic                          resolve_pred_hit,
    input  logic                          resolve_pred_taken,
    input  bpred_pkg::word_t              resolve_pred_target,

    output logic [perf_counter_width-1:0] cf_count,
    output logic                          cf_overflow,
    output logic [perf_counter_width-1:0] correct_count,
    output logic                          correct_overflow
);

    bpred_pkg::word_t cmp_target;
    logic             target_ok;
    logic             correct;

    // jalr is judged against the bit-0 cleared target, as the BTB stores it
    assign cmp_target = (resolve_kind == bpred_pkg::cf_jalr) ?
                        {resolve_target[31:1], 1'b0} : resolve_target;
    assign target_ok  = resolve_pred_target == cmp_target;

    always_comb begin
        correct = 1'b0;
        unique case (resolve_kind)
            bpred_pkg::cf_br: begin
                if (resolve_pred_hit) begin
                    correct = (resolve_pred_taken == resolve_taken) &&
                              (!resolve_taken || target_ok);
                end else begin
                    correct = !resolve_taken; // fall-through was right
                end
            end
            bpred_pkg::cf_jal,
            bpred_pkg::cf_jalr: correct = resolve_pred_hit && target_ok;
            default: correct = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cf_count         <= '0;
            cf_overflow      <= 1'b0;
            correct_count    <= '0;
            correct_overflow <= 1'b0;
        end else if (resolve_valid) begin
            cf_count <= cf_count + 1'b1; // wraps
            if (&cf_count) begin
                cf_overflow <= 1'b1; // sticky
            end
            if (correct) begin
                correct_count <= correct_count + 1'b1;
                if (&correct_count) begin
                    correct_overflow <= 1'b1;
                end
            end
        end
    end

endmodule : bpred_perf

// ==== hw/bpred_top.sv ====
`timescale 1ns/10ps

module bpred_top #(
    parameter int history_depth      = 8,
    parameter int bht_s_index        = 6,
    parameter int btb_s_index        = 5,
    parameter int perf_counter_width = 16
) (
    input  logic                          clk,
    input  logic                          arst_n,

    // lookup
    input  logic                          lookup_valid,
    input  bpred_pkg::word_t              lookup_pc,

    // prediction one cycle after lookup
    output logic                          pred_valid,
    output logic                          pred_hit,
    output logic                          pred_taken,
    output bpred_pkg::word_t              pred_target,
    output bpred_pkg::cf_kind_t           pred_kind,

    // resolution
    input  logic                          resolve_valid,
    input  bpred_pkg::word_t              resolve_pc,
    input  bpred_pkg::cf_kind_t           resolve_kind,
    input  logic                          resolve_taken,
    input  bpred_pkg::word_t              resolve_target,
    input  logic                          resolve_pred_hit,
    input  logic                          resolve_pred_taken,
    input  bpred_pkg::word_t              resolve_pred_target,

    // performance counters
    output logic [perf_counter_width-1:0] cf_count,
    output logic                          cf_overflow,
    output logic [perf_counter_width-1:0] correct_count,
    output logic                          correct_overflow
);

    logic [bpred_pkg::num_pht-1:0][history_depth-1:0] read_index;
    logic [bpred_pkg::num_pht-1:0][history_depth-1:0] write_index;
    bpred_pkg::ctr_t [bpred_pkg::num_pht-1:0]         read_ctr;
    bpred_pkg::ctr_t [bpred_pkg::num_pht-1:0]         write_ctr;
    logic [bpred_pkg::num_pht-1:0]                    bank_increment;
    logic [bpred_pkg::num_pht-1:0]                    bank_decrement;

    logic                branch_taken;
    logic                btb_hit;
    bpred_pkg::word_t    btb_target;
    bpred_pkg::cf_kind_t btb_kind;
    logic                taken_next;

    predictor_index #(
        .history_depth(history_depth),
        .bht_s_index  (bht_s_index)
    ) i_predictor_index (
        .clk          (clk),
        .arst_n       (arst_n),
        .lookup_pc    (lookup_pc),
        .resolve_valid(resolve_valid),
        .resolve_pc   (resolve_pc),
        .resolve_kind (resolve_kind),
        .resolve_taken(resolve_taken),
        .read_index   (read_index),
        .write_index  (write_index)
    );

    // global, local and chooser tables
    for (genvar g = 0; g < bpred_pkg::num_pht; g++) begin : g_pht
        pht_bank #(
            .history_depth(history_depth)
        ) i_pht_bank (
            .clk        (clk),
            .arst_n     (arst_n),
            .read_index (read_index[g]),
            .write_index(write_index[g]),
            .increment  (bank_increment[g]),
            .decrement  (bank_decrement[g]),
            .read_ctr   (read_ctr[g]),
            .write_ctr  (write_ctr[g])
        );
    end

    tournament_select i_tournament_select (
        .read_ctr      (read_ctr),
        .write_ctr     (write_ctr),
        .resolve_valid (resolve_valid),
        .resolve_kind  (resolve_kind),
        .resolve_taken (resolve_taken),
        .branch_taken  (branch_taken),
        .bank_increment(bank_increment),
        .bank_decrement(bank_decrement)
    );

    btb #(
        .btb_s_index(btb_s_index)
    ) i_btb (
        .clk           (clk),
        .arst_n        (arst_n),
        .lookup_pc     (lookup_pc),
        .resolve_valid (resolve_valid),
        .resolve_pc    (resolve_pc),
        .resolve_kind  (resolve_kind),
        .resolve_target(resolve_target),
        .hit           (btb_hit),
        .target        (btb_target),
        .kind          (btb_kind)
    );

    bpred_perf #(
        .perf_counter_width(perf_counter_width)
    ) i_bpred_perf (
        .clk                (clk),
        .arst_n             (arst_n),
        .resolve_valid      (resolve_valid),
        .resolve_kind       (resolve_kind),
        .resolve_taken      (resolve_taken),
        .resolve_target     (resolve_target),
        .resolve_pred_hit   (resolve_pred_hit),
        .resolve_pred_taken (resolve_pred_taken),
        .resolve_pred_target(resolve_pred_target),
        .cf_count           (cf_count),
        .cf_overflow        (cf_overflow),
        .correct_count      (correct_count),
        .correct_overflow   (correct_overflow)
    );

    // jumps always taken and branches follow the tournament
    assign taken_next = btb_hit &&
                        ((btb_kind == bpred_pkg::cf_br) ? branch_taken : 1'b1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pred_valid  <= 1'b0;
            pred_hit    <= 1'b0;
            pred_taken  <= 1'b0;
            pred_target <= '0;
            pred_kind   <= bpred_pkg::cf_br;
        end else begin
            pred_valid <= lookup_valid; // one-cycle strobe per lookup
            if (lookup_valid) begin
                pred_hit    <= btb_hit;
                pred_taken  <= taken_next;
                pred_target <= btb_target;
                pred_kind   <= btb_kind;
            end
        end
    end

endmodule : bpred_top

// ==== tests/bpred_model.svh ====
`ifndef BPRED_MODEL_SVH
`define BPRED_MODEL_SVH

// expected predictor state stepped once per resolution
logic [hist_bits-1:0]   m_ghr;
logic [hist_bits-1:0]   m_bht [2**bht_bits];
bpred_pkg::ctr_t        m_pht [bpred_pkg::num_pht][2**hist_bits];
logic                   m_btb_valid  [2**btb_bits];
logic [29-btb_bits:0]   m_btb_tag    [2**btb_bits];
bpred_pkg::word_t       m_btb_target [2**btb_bits];
bpred_pkg::cf_kind_t    m_btb_kind   [2**btb_bits];
logic [perf_bits-1:0]   m_cf_count;
logic [perf_bits-1:0]   m_correct_count;
logic                   m_cf_overflow;
logic                   m_correct_overflow;
logic [15:0]            lfsr_state = 16'd26767;

// galois lfsr stepped once per bit
function automatic logic rand_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
        lfsr_state = lfsr_state ^ 16'hb400;
    end
    return lsb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value = {value[30:0], rand_bit()};
    end
    return value;
endfunction

function automatic bpred_pkg::ctr_t sat_step(input bpred_pkg::ctr_t c, input logic up);
    if (up) begin
        return (c == 2'b11) ? c : c + 2'd1;
    end
    return (c == 2'b00) ? c : c - 2'd1;
endfunction

task automatic model_reset();
    m_ghr = '0;
    foreach (m_bht[i]) begin
        m_bht[i] = '0;
    end
    foreach (m_pht[b, i]) begin
        m_pht[b][i] = 2'b01; // weakly not taken, weakly local
    end
    foreach (m_btb_valid[i]) begin
        m_btb_valid[i] = 1'b0;
    end
    m_cf_count         = '0;
    m_correct_count    = '0;
    m_cf_overflow      = 1'b0;
    m_correct_overflow = 1'b0;
endtask

function automatic void model_predict(input bpred_pkg::word_t pc, output logic hit,
                                      output logic taken, output bpred_pkg::word_t target,
                                      output bpred_pkg::cf_kind_t kind);
    int  idx;
    logic global_dir;
    logic local_dir;
    logic use_global;
    idx        = pc[btb_bits+1:2];
    hit        = m_btb_valid[idx] && (m_btb_tag[idx] == pc[31:btb_bits+2]);
    target     = hit ? m_btb_target[idx] : '0;
    kind       = hit ? m_btb_kind[idx] : bpred_pkg::cf_br;
    global_dir = m_pht[bpred_pkg::pht_global][m_ghr][1];
    local_dir  = m_pht[bpred_pkg::pht_local][m_bht[pc[bht_bits+1:2]]][1];
    use_global = m_pht[bpred_pkg::pht_chooser][pc[hist_bits+1:2]][1];
    if (!hit) begin
        taken = 1'b0;
    end else if (kind != bpred_pkg::cf_br) begin
        taken = 1'b1; // jumps always go
    end else begin
        taken = use_global ? global_dir : local_dir;
    end
endfunction

// target here is the stored form with bit 0 cleared for jalr
function automatic logic resolve_correct(input bpred_pkg::cf_kind_t kind, input logic taken,
                                         input bpred_pkg::word_t target, input logic ph,
                                         input logic pt, input bpred_pkg::word_t ptgt);
    if (kind == bpred_pkg::cf_br) begin
        if (ph) begin
            return (pt == taken) && (!taken || (ptgt == target));
        end
        return !taken;
    end
    return ph && (ptgt == target);
endfunction

task automatic model_resolve(input bpred_pkg::word_t pc, input bpred_pkg::cf_kind_t kind,
                             input logic taken, input bpred_pkg::word_t target,
                             input logic ph, input logic pt, input bpred_pkg::word_t ptgt);
    int               idx;
    int               gi;
    int               li;
    int               ci;
    bpred_pkg::word_t stored;
    stored = (kind == bpred_pkg::cf_jalr) ? {target[31:1], 1'b0} : target;
    idx    = pc[btb_bits+1:2];
    m_btb_valid[idx]  = 1'b1;
    m_btb_tag[idx]    = pc[31:btb_bits+2];
    m_btb_target[idx] = stored;
    m_btb_kind[idx]   = kind;
    if (kind == bpred_pkg::cf_br) begin
        gi = m_ghr;
        li = m_bht[pc[bht_bits+1:2]];
        ci = pc[hist_bits+1:2];
        if (m_pht[bpred_pkg::pht_global][gi][1] != m_pht[bpred_pkg::pht_local][li][1]) begin
            m_pht[bpred_pkg::pht_chooser][ci] = sat_step(m_pht[bpred_pkg::pht_chooser][ci],
                m_pht[bpred_pkg::pht_global][gi][1] == taken);
        end
        m_pht[bpred_pkg::pht_global][gi] = sat_step(m_pht[bpred_pkg::pht_global][gi], taken);
        m_pht[bpred_pkg::pht_local][li]  = sat_step(m_pht[bpred_pkg::pht_local][li], taken);
        m_ghr = {m_ghr[hist_bits-2:0], taken};
        m_bht[pc[bht_bits+1:2]] = {m_bht[pc[bht_bits+1:2]][hist_bits-2:0], taken};
    end
    if (m_cf_count == '1) begin
        m_cf_overflow = 1'b1;
    end
    m_cf_count = m_cf_count + 1'b1;
    if (resolve_correct(kind, taken, stored, ph, pt, ptgt)) begin
        if (m_correct_count == '1) begin
            m_correct_overflow = 1'b1;
        end
        m_correct_count = m_correct_count + 1'b1;
    end
endtask

`endif

// ==== tests/bpred_tb.sv ====
`timescale 1ns/10ps

module bpred_tb;

    localparam int hist_bits    = 8;
    localparam int bht_bits     = 6;
    localparam int btb_bits     = 5;
    localparam int perf_bits    = 6; // small so the counters wrap
    localparam int num_directed = 35;
    localparam int num_random   = 400;
    localparam int num_ops      = num_directed + num_random;

    logic                  clk;
    logic                  arst_n;
    logic                  lookup_valid;
    bpred_pkg::word_t      lookup_pc;
    logic                  pred_valid;
    logic                  pred_hit;
    logic                  pred_taken;
    bpred_pkg::word_t      pred_target;
    bpred_pkg::cf_kind_t   pred_kind;
    logic                  resolve_valid;
    bpred_pkg::word_t      resolve_pc;
    bpred_pkg::cf_kind_t   resolve_kind;
    logic                  resolve_taken;
    bpred_pkg::word_t      resolve_target;
    logic                  resolve_pred_hit;
    logic                  resolve_pred_taken;
    bpred_pkg::word_t      resolve_pred_target;
    logic [perf_bits-1:0]  cf_count;
    logic                  cf_overflow;
    logic [perf_bits-1:0]  correct_count;
    logic                  correct_overflow;

    logic                  exp_valid;
    logic                  exp_hit;
    logic                  exp_taken;
    bpred_pkg::word_t      exp_target;
    bpred_pkg::cf_kind_t   exp_kind;
    int                    value_errors;
    int                    strobe_errors;

    `include "bpred_model.svh"

    bpred_top #(
        .history_depth     (hist_bits),
        .bht_s_index       (bht_bits),
        .btb_s_index       (btb_bits),
        .perf_counter_width(perf_bits)
    ) i_bpred_top (
        .clk                (clk),
        .arst_n             (arst_n),
        .lookup_valid       (lookup_valid),
        .lookup_pc          (lookup_pc),
        .pred_valid         (pred_valid),
        .pred_hit           (pred_hit),
        .pred_taken         (pred_taken),
        .pred_target        (pred_target),
        .pred_kind          (pred_kind),
        .resolve_valid      (resolve_valid),
        .resolve_pc         (resolve_pc),
        .resolve_kind       (resolve_kind),
        .resolve_taken      (resolve_taken),
        .resolve_target     (resolve_target),
        .resolve_pred_hit   (resolve_pred_hit),
        .resolve_pred_taken (resolve_pred_taken),
        .resolve_pred_target(resolve_pred_target),
        .cf_count           (cf_count),
        .cf_overflow        (cf_overflow),
        .correct_count      (correct_count),
        .correct_overflow   (correct_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected,
                     actual);
            value_errors++;
        end
    endtask

    // results of the lookup and resolution driven one cycle earlier
    task automatic check_outputs();
        assert (pred_valid === exp_valid) else begin
            if (exp_valid) begin
                $display("%0t: no pred_valid one cycle after a lookup", $time);
            end else begin
                $display("%0t: pred_valid raised without a lookup", $time);
            end
            strobe_errors++;
        end
        if (exp_valid && pred_valid === 1'b1) begin
            check_value("pred_hit", exp_hit, pred_hit);
            check_value("pred_taken", exp_taken, pred_taken);
            check_value("pred_target", exp_target, pred_target);
            check_value("pred_kind", exp_kind, pred_kind);
        end
        check_value("cf_count", m_cf_count, cf_count);
        check_value("cf_overflow", m_cf_overflow, cf_overflow);
        check_value("correct_count", m_correct_count, correct_count);
        check_value("correct_overflow", m_correct_overflow, correct_overflow);
    endtask

    task automatic drive_cycle(input logic lv, input bpred_pkg::word_t lpc, input logic rv,
                               input bpred_pkg::word_t rpc, input bpred_pkg::cf_kind_t rkind,
                               input logic rtaken, input bpred_pkg::word_t rtgt,
                               input logic rph, input logic rpt, input bpred_pkg::word_t rptgt);
        @(negedge clk);
        check_outputs();
        lookup_valid        = lv;
        lookup_pc           = lpc;
        resolve_valid       = rv;
        resolve_pc          = rpc;
        resolve_kind        = rkind;
        resolve_taken       = rtaken;
        resolve_target      = rtgt;
        resolve_pred_hit    = rph;
        resolve_pred_taken  = rpt;
        resolve_pred_target = rptgt;
        exp_valid = lv;
        if (lv) begin
            model_predict(lpc, exp_hit, exp_taken, exp_target, exp_kind); // old state
        end
        if (rv) begin
            model_resolve(rpc, rkind, rtaken, rtgt, rph, rpt, rptgt);
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b0, '0, bpred_pkg::cf_br, 1'b0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic lookup_only(input bpred_pkg::word_t pc);
        drive_cycle(1'b1, pc, 1'b0, '0, bpred_pkg::cf_br, 1'b0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic resolve_only(input bpred_pkg::word_t pc, input bpred_pkg::cf_kind_t kind,
                                input logic taken, input bpred_pkg::word_t target);
        drive_cycle(1'b0, '0, 1'b1, pc, kind, taken, target, 1'b0, 1'b0, '0);
    endtask

    // 32 pcs over 8 btb slots, so entries alias
    function automatic bpred_pkg::word_t pool_pc();
        logic [31:0] idx_bits;
        logic [31:0] tag_bits;
        idx_bits = rand_bits(3);
        tag_bits = rand_bits(2);
        return 32'h0000_1000 | (tag_bits << 7) | (idx_bits << 2);
    endfunction

    task automatic random_cycle();
        logic                lv;
        logic                rv;
        logic                rtaken;
        logic                rph;
        logic                rpt;
        logic [31:0]         k;
        bpred_pkg::word_t    lpc;
        bpred_pkg::word_t    rpc;
        bpred_pkg::word_t    rtgt;
        bpred_pkg::word_t    stored;
        bpred_pkg::word_t    rptgt;
        bpred_pkg::cf_kind_t rkind;
        lv  = rand_bits(2) != 0;
        lpc = pool_pc();
        rv  = rand_bits(2) != 0;
        rpc = pool_pc();
        k   = rand_bits(2);
        rkind  = (k == 1) ? bpred_pkg::cf_jal : (k == 2) ? bpred_pkg::cf_jalr : bpred_pkg::cf_br;
        rtaken = (rkind == bpred_pkg::cf_br) ? rand_bit() : 1'b1;
        rtgt   = 32'h0000_2000 | rand_bits(10);
        stored = (rkind == bpred_pkg::cf_jalr) ? {rtgt[31:1], 1'b0} : rtgt;
        rph    = rand_bit();
        rpt    = rand_bit();
        rptgt  = rand_bit() ? stored : (32'h0000_2000 | rand_bits(10)); // right or wrong echo
        drive_cycle(lv, lpc, rv, rpc, rkind, rtaken, rtgt, rph, rpt, rptgt);
    endtask

    initial begin
        arst_n = 1'b0;
        lookup_valid = 1'b0;
        lookup_pc = '0;
        resolve_valid = 1'b0;
        resolve_pc = '0;
        resolve_kind = bpred_pkg::cf_br;
        resolve_taken = 1'b0;
        resolve_target = '0;
        resolve_pred_hit = 1'b0;
        resolve_pred_taken = 1'b0;
        resolve_pred_target = '0;
        exp_valid = 1'b0;
        value_errors = 0;
        strobe_errors = 0;
        model_reset();
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // empty tables
        idle_cycle();
        lookup_only(32'h0000_0100);

        // jumps, then an alias on the same btb slot
        resolve_only(32'h0000_0100, bpred_pkg::cf_jal, 1'b1, 32'h0000_0400);
        resolve_only(32'h0000_0104, bpred_pkg::cf_jalr, 1'b1, 32'h0000_0803);
        lookup_only(32'h0000_0100);
        lookup_only(32'h0000_0104);
        lookup_only(32'h0000_0180);

        // a branch trained one way, then the other
        repeat (12) resolve_only(32'h0000_0200, bpred_pkg::cf_br, 1'b1, 32'h0000_0240);
        lookup_only(32'h0000_0200);
        repeat (12) resolve_only(32'h0000_0200, bpred_pkg::cf_br, 1'b0, 32'h0000_0240);
        lookup_only(32'h0000_0200);

        for (int i = 0; i < num_random; i++) begin
            random_cycle();
        end
        idle_cycle();
        idle_cycle();

        assert (cf_overflow === 1'b1 && correct_overflow === 1'b1) else begin
            $display("the random traffic never wrapped both performance counters");
            value_errors++;
        end

        $display("errors: %0d value, %0d strobe", value_errors, strobe_errors);
        if (value_errors == 0 && strobe_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // two clock periods per operation
    initial begin
        #(num_ops * 80);
        $display("timeout: the run did not finish in %0d ns", num_ops * 80);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : bpred_tb

// ==== bpred_top.f ====
+incdir+tests
hw/bpred_pkg.sv
hw/predictor_index.sv
hw/pht_bank.sv
hw/tournament_select.sv
hw/btb.sv
hw/bpred_perf.sv
hw/bpred_top.sv
tests/bpred_tb.sv
